// ==== hw/tpu_pkg.sv ====
package tpu_pkg;

    // operand and accumulator widths
    localparam int ELEM_W = 8;
    localparam int ACC_W  = 32;

    // buffer addressing and job dimensions
    localparam int IDX_W = 16;
    localparam int DIM_W = 8;

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [DIM_W-1:0]  dim_t;  // K, M, N or a tile count

    // tile loop: read covers fetch, skew and drain, output writes C rows
    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_output,
        st_finish
    } tpu_state_e;

endpackage

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  acc_clear,
    input  logic  acc_en,
    input  elem_t west,
    input  elem_t north,
    output elem_t east,
    output elem_t south,
    output acc_t  psum
);

    logic [2*ELEM_W-1:0] prod;

    assign prod = west * north;  // unsigned, never overflows 16 bits

    // accumulator wraps at 32 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum <= '0;
        end else if (acc_clear) begin
            psum <= '0;
        end else if (acc_en) begin
            psum <= psum + acc_t'(prod);
        end
    end

    // operands move one PE per cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            east  <= '0;
            south <= '0;
        end else begin
            east  <= west;
            south <= north;
        end
    end

endmodule

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array import tpu_pkg::*; #(
    parameter int array_dim = 4
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic                                         acc_clear,
    input  logic                                         acc_en,
    input  logic [array_dim*ELEM_W-1:0]                  west_lanes,
    input  logic [array_dim*ELEM_W-1:0]                  north_lanes,
    output wire  [array_dim-1:0][array_dim*ACC_W-1:0]    psum_rows
);

    // registered operand outputs of every PE
    elem_t east_w  [array_dim][array_dim];
    elem_t south_w [array_dim][array_dim];

    for (genvar r = 0; r < array_dim; r++) begin : g_row
        for (genvar c = 0; c < array_dim; c++) begin : g_col
            elem_t w_in;
            elem_t n_in;

            // west edge from the A skewer, lane 0 in the top byte
            if (c == 0) begin : g_w_edge
                assign w_in = west_lanes[(array_dim-1-r)*ELEM_W +: ELEM_W];
            end else begin : g_w_inner
                assign w_in = east_w[r][c-1];
            end

            // north edge from the B skewer
            if (r == 0) begin : g_n_edge
                assign n_in = north_lanes[(array_dim-1-c)*ELEM_W +: ELEM_W];
            end else begin : g_n_inner
                assign n_in = south_w[r-1][c];
            end

            mac_pe u_pe (
                .clk       (clk),
                .rst_n     (rst_n),
                .acc_clear (acc_clear),
                .acc_en    (acc_en),
                .west      (w_in),
                .north     (n_in),
                .east      (east_w[r][c]),
                .south     (south_w[r][c]),
                .psum      (psum_rows[r][(array_dim-1-c)*ACC_W +: ACC_W])  // column 0 on top
            );
        end
    end

endmodule

// ==== hw/operand_skewer.sv ====
`timescale 1ns/1ps

module operand_skewer import tpu_pkg::*; #(
    parameter int array_dim = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  tpu_state_e                    state,
    input  dim_t                          k_count,
    input  dim_t                          k,
    input  logic [array_dim*ELEM_W-1:0]   word,
    output logic [array_dim*ELEM_W-1:0]   lanes
);

    logic load_q;  // buffer word on the port belongs to the job

    // buffer answers one cycle after the fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_q <= 1'b0;
        end else begin
            load_q <= (state == st_read) && (k_count < k);
        end
    end

    for (genvar r = 0; r < array_dim; r++) begin : g_lane
        localparam int SR_W = (r + 1) * ELEM_W;

        logic [SR_W-1:0] sr;  // depth r+1 gives r cycles of skew
        elem_t           in_byte;

        assign in_byte = load_q ? word[(array_dim-1-r)*ELEM_W +: ELEM_W] : '0;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sr <= '0;
            end else if (state == st_idle) begin
                sr <= '0;
            end else if (state == st_read) begin
                sr <= (sr << ELEM_W) | SR_W'(in_byte);  // zero fill once K is done
            end
        end

        assign lanes[(array_dim-1-r)*ELEM_W +: ELEM_W] = sr[SR_W-1 -: ELEM_W];
    end

    // a tile never starts with stale operands in the pipe
    a_lanes_clear : assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_read && k_count == '0) |-> lanes == '0);

endmodule

// ==== hw/tile_controller.sv ====
`timescale 1ns/1ps

module tile_controller import tpu_pkg::*; #(
    parameter int array_dim = 4
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       start,
    input  dim_t                                       k,
    input  dim_t                                       m,
    input  dim_t                                       n,
    output tpu_state_e                                 state,
    output dim_t                                       k_count,
    output logic                                       acc_clear,
    output logic                                       acc_en,
    output logic                                       done,
    input  logic [array_dim-1:0][array_dim*ACC_W-1:0]  psum_rows,
    output idx_t                                       a_index,
    output idx_t                                       b_index,
    output idx_t                                       c_index,
    output logic                                       c_wr_en,
    output logic [array_dim*ACC_W-1:0]                 c_data_in
);

    localparam int ROW_W = $clog2(array_dim);
    localparam int DRAIN = 3 * array_dim;  // fetch latency, skew and drain

    tpu_state_e state_nxt;
    idx_t       read_cnt;   // cycles since the tile began
    idx_t       read_last;
    idx_t       a_base;     // ti * K
    idx_t       b_base;     // tj * K
    dim_t       row_tiles;
    dim_t       col_tiles;
    dim_t       ti;
    dim_t       tj;
    dim_t       out_row;
    dim_t       rows_last;
    dim_t       rows_this;
    logic       fetch;
    logic       last_i;
    logic       last_j;
    logic       last_row;

    // tile counts, rounded up
    assign row_tiles = dim_t'((int'(m) + array_dim - 1) / array_dim);
    assign col_tiles = dim_t'((int'(n) + array_dim - 1) / array_dim);
    assign rows_last = dim_t'(int'(m) % array_dim);

    assign last_i    = int'(ti) + 1 >= int'(row_tiles);
    assign last_j    = int'(tj) + 1 >= int'(col_tiles);
    assign rows_this = (last_i && rows_last != '0) ? rows_last : dim_t'(array_dim);
    assign last_row  = out_row == rows_this - dim_t'(1);

    assign read_last = idx_t'(k) + idx_t'(DRAIN - 1);

    // saturates so a long drain never looks like a fetch cycle
    assign k_count = (read_cnt[IDX_W-1:DIM_W] != '0) ? '1 : read_cnt[DIM_W-1:0];

    assign fetch   = (state == st_read) && (k_count < k);
    assign a_index = fetch ? a_base + idx_t'(k_count) : a_base;
    assign b_index = fetch ? b_base + idx_t'(k_count) : b_base;

    assign acc_clear = (state == st_read) && (read_cnt == '0);
    assign acc_en    = state == st_read;
    assign done      = state == st_finish;

    // one C row per output cycle
    assign c_wr_en   = state == st_output;
    assign c_data_in = psum_rows[out_row[ROW_W-1:0]];

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_read;
                end
            end
            st_read: begin
                if (read_cnt == read_last) begin
                    state_nxt = st_output;
                end
            end
            st_output: begin
                if (last_row) begin
                    state_nxt = (last_i && last_j) ? st_finish : st_read;
                end
            end
            st_finish: state_nxt = st_idle;
            default:   state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // read cycle and output row counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_cnt <= '0;
            out_row  <= '0;
        end else begin
            read_cnt <= (state == st_read) ? read_cnt + idx_t'(1) : '0;
            out_row  <= (state == st_output) ? out_row + dim_t'(1) : '0;
        end
    end

    // tile loop with i inner and j outer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ti     <= '0;
            tj     <= '0;
            a_base <= '0;
            b_base <= '0;
        end else if (state == st_idle) begin
            ti     <= '0;
            tj     <= '0;
            a_base <= '0;
            b_base <= '0;
        end else if (state == st_output && last_row) begin
            if (last_i) begin
                ti     <= '0;
                a_base <= '0;
                tj     <= tj + dim_t'(1);
                b_base <= b_base + idx_t'(k);
            end else begin
                ti     <= ti + dim_t'(1);
                a_base <= a_base + idx_t'(k);
            end
        end
    end

    // C rows land at consecutive indices per job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_index <= '0;
        end else if (state == st_idle) begin
            c_index <= '0;
        end else if (c_wr_en) begin
            c_index <= c_index + idx_t'(1);
        end
    end

    // short last row tile never writes past M
    a_wr_in_output : assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> out_row < rows_this);

    // every column tile holds M rows, every full row tile array_dim rows
    a_c_index_step : assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> int'(c_index) ==
            int'(tj) * int'(m) + int'(ti) * array_dim + int'(out_row));

endmodule

// ==== hw/tpu_top.sv ====
`timescale 1ns/1ps

module tpu_top import tpu_pkg::*; #(
    parameter int array_dim = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  dim_t                          k,
    input  dim_t                          m,
    input  dim_t                          n,
    output logic                          busy,
    output idx_t                          a_index,
    output idx_t                          b_index,
    input  logic [array_dim*ELEM_W-1:0]   a_data_out,
    input  logic [array_dim*ELEM_W-1:0]   b_data_out,
    output logic                          c_wr_en,
    output idx_t                          c_index,
    output logic [array_dim*ACC_W-1:0]    c_data_in
);

    logic                                      start;
    dim_t                                      k_r;
    dim_t                                      m_r;
    dim_t                                      n_r;
    tpu_state_e                                state;
    dim_t                                      k_count;
    logic                                      acc_clear;
    logic                                      acc_en;
    logic                                      done;
    logic [array_dim*ELEM_W-1:0]               west_lanes;
    logic [array_dim*ELEM_W-1:0]               north_lanes;
    logic [array_dim-1:0][array_dim*ACC_W-1:0] psum_rows;

    // ignored while busy or with an empty K
    assign start = in_valid && !busy && (k != '0);

    always_ff @(posedge clk) begin
        if (start) begin
            k_r <= k;
            m_r <= m;
            n_r <= n;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;  // drops on the edge after finish
        end
    end

    tile_controller #(.array_dim(array_dim)) u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .k         (k_r),
        .m         (m_r),
        .n         (n_r),
        .state     (state),
        .k_count   (k_count),
        .acc_clear (acc_clear),
        .acc_en    (acc_en),
        .done      (done),
        .psum_rows (psum_rows),
        .a_index   (a_index),
        .b_index   (b_index),
        .c_index   (c_index),
        .c_wr_en   (c_wr_en),
        .c_data_in (c_data_in)
    );

    // rows of A enter from the west
    operand_skewer #(.array_dim(array_dim)) a_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .state   (state),
        .k_count (k_count),
        .k       (k_r),
        .word    (a_data_out),
        .lanes   (west_lanes)
    );

    // columns of B enter from the north
    operand_skewer #(.array_dim(array_dim)) b_skew (
        .clk     (clk),
        .rst_n   (rst_n),
        .state   (state),
        .k_count (k_count),
        .k       (k_r),
        .word    (b_data_out),
        .lanes   (north_lanes)
    );

    systolic_array #(.array_dim(array_dim)) u_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .acc_clear   (acc_clear),
        .acc_en      (acc_en),
        .west_lanes  (west_lanes),
        .north_lanes (north_lanes),
        .psum_rows   (psum_rows)
    );

endmodule

// ==== verification/tb_tpu.sv ====
`timescale 1ns/1ps

module tb_tpu;

    localparam int array_dim = 4;
    localparam int elem_w    = 8;
    localparam int acc_w     = 32;
    localparam int ab_w      = array_dim * elem_w;
    localparam int c_w       = array_dim * acc_w;
    localparam int mem_depth = 64;
    localparam int mem_aw    = $clog2(mem_depth);
    localparam int mat_dim   = 16;
    localparam int job_count = 6;

    // job table: K, M, N, expected number of C writes, extra in_valid while busy
    localparam int job_k    [job_count] = '{4, 1, 7, 3, 16, 0};
    localparam int job_m    [job_count] = '{4, 4, 6, 9, 8, 4};
    localparam int job_n    [job_count] = '{4, 4, 5, 2, 12, 4};
    localparam int job_wr   [job_count] = '{4, 4, 12, 9, 24, 0};
    localparam bit job_poke [job_count] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    logic            clk = 1'b0;
    logic            rst_n;
    logic            in_valid;
    logic [7:0]      k;
    logic [7:0]      m;
    logic [7:0]      n;
    logic            busy;
    logic [15:0]     a_index;
    logic [15:0]     b_index;
    logic [ab_w-1:0] a_data_out = '0;
    logic [ab_w-1:0] b_data_out = '0;
    logic            c_wr_en;
    logic [15:0]     c_index;
    logic [c_w-1:0]  c_data_in;

    logic [ab_w-1:0] a_mem   [mem_depth];
    logic [ab_w-1:0] b_mem   [mem_depth];
    logic [c_w-1:0]  c_mem   [mem_depth];
    logic [c_w-1:0]  exp_mem [mem_depth];
    logic [7:0]      mat_a   [mat_dim][mat_dim];  // row, k
    logic [7:0]      mat_b   [mat_dim][mat_dim];  // k, column

    logic [31:0] lfsr_state = 32'h1770;
    int          wr_total   = 0;  // all C writes seen so far
    int          job_base   = 0;  // wr_total when the current job began
    int          write_errs = 0;
    int          check_errs = 0;

    always #2 clk = ~clk;

    tpu_top #(.array_dim(array_dim)) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .k          (k),
        .m          (m),
        .n          (n),
        .busy       (busy),
        .a_index    (a_index),
        .b_index    (b_index),
        .a_data_out (a_data_out),
        .b_data_out (b_data_out),
        .c_wr_en    (c_wr_en),
        .c_index    (c_index),
        .c_data_in  (c_data_in)
    );

    // synchronous A and B buffers, data one cycle after the index
    always @(posedge clk) begin
        a_data_out <= a_mem[a_index[mem_aw-1:0]];
        b_data_out <= b_mem[b_index[mem_aw-1:0]];
    end

    // C buffer, also watches the write path
    always @(posedge clk) begin
        if (c_wr_en) begin
            assert (busy) else begin
                write_errs++;
                $display("C write at index %0d at %0t while busy is low", c_index, $time);
            end
            assert (c_index == 16'(wr_total - job_base)) else begin
                write_errs++;
                show_mismatch("c_index", c_w'(wr_total - job_base), c_w'(c_index));
            end
            if (int'(c_index) < mem_depth) begin
                c_mem[c_index[mem_aw-1:0]] <= c_data_in;
            end
            wr_total <= wr_total + 1;
        end
    end

    task automatic show_mismatch(input string name, input logic [c_w-1:0] exp,
                                 input logic [c_w-1:0] act);
        $display("ERR t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        assert (act === exp) else begin
            check_errs++;
            show_mismatch(name, c_w'(exp), c_w'(act));
        end
    endtask

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic next_random_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], next_random_bit()};
        end
        return b;
    endfunction

    function automatic int tile_count(input int idx);
        return ((job_m[idx] + array_dim - 1) / array_dim) *
               ((job_n[idx] + array_dim - 1) / array_dim);
    endfunction

    task automatic clear_buffers();
        for (int i = 0; i < mem_depth; i++) begin
            a_mem[i] = '0;
            b_mem[i] = '0;
        end
    endtask

    // padding outside M, N and K stays zero
    task automatic fill_matrices(input int jk, input int jm, input int jn);
        for (int r = 0; r < mat_dim; r++) begin
            for (int c = 0; c < mat_dim; c++) begin
                mat_a[r][c] = (r < jm && c < jk) ? random_byte() : 8'h00;
                mat_b[r][c] = (r < jk && c < jn) ? random_byte() : 8'h00;
            end
        end
    endtask

    task automatic load_buffers(input int jk, input int jm, input int jn);
        int row_tiles;
        int col_tiles;
        row_tiles = (jm + array_dim - 1) / array_dim;
        col_tiles = (jn + array_dim - 1) / array_dim;
        clear_buffers();
        for (int kk = 0; kk < jk; kk++) begin
            for (int r = 0; r < array_dim; r++) begin
                for (int i = 0; i < row_tiles; i++) begin  // row 4i in the top byte
                    a_mem[i*jk+kk][(array_dim-1-r)*elem_w +: elem_w] =
                        mat_a[i*array_dim+r][kk];
                end
                for (int j = 0; j < col_tiles; j++) begin
                    b_mem[j*jk+kk][(array_dim-1-r)*elem_w +: elem_w] =
                        mat_b[kk][j*array_dim+r];
                end
            end
        end
    endtask

    // C rows in j-major, i, row order, sums wrap at 32 bits
    task automatic build_expected(input int jk, input int jm, input int jn, output int count);
        int               row_tiles;
        int               col_tiles;
        int               rows;
        logic [acc_w-1:0] sum;
        row_tiles = (jm + array_dim - 1) / array_dim;
        col_tiles = (jn + array_dim - 1) / array_dim;
        count     = 0;
        for (int j = 0; j < col_tiles; j++) begin
            for (int i = 0; i < row_tiles; i++) begin
                rows = (i == row_tiles - 1 && jm % array_dim != 0) ? jm % array_dim : array_dim;
                for (int rr = 0; rr < rows; rr++) begin
                    for (int c = 0; c < array_dim; c++) begin
                        sum = '0;
                        for (int kk = 0; kk < jk && j*array_dim + c < jn; kk++) begin
                            sum = sum + 32'(mat_a[i*array_dim+rr][kk]) *
                                        32'(mat_b[kk][j*array_dim+c]);
                        end
                        exp_mem[count][(array_dim-1-c)*acc_w +: acc_w] = sum;
                    end
                    count++;
                end
            end
        end
    endtask

    task automatic run_job(input int idx);
        int jk;
        int jm;
        int jn;
        int exp_count;
        int got;
        jk        = job_k[idx];
        jm        = job_m[idx];
        jn        = job_n[idx];
        exp_count = 0;
        if (jk != 0) begin
            fill_matrices(jk, jm, jn);
            load_buffers(jk, jm, jn);
            build_expected(jk, jm, jn, exp_count);
        end
        assert (exp_count == job_wr[idx]) else begin
            check_errs++;
            $display("job %0d: table and model disagree on the number of C rows", idx);
        end
        job_base = wr_total;  // c_index restarts at 0 here

        @(posedge clk);
        in_valid <= 1'b1;
        k        <= 8'(jk);
        m        <= 8'(jm);
        n        <= 8'(jn);
        @(posedge clk);
        in_valid <= 1'b0;
        check_flag("busy", busy, 1'b0);
        @(posedge clk);
        check_flag("busy", busy, jk != 0);  // one cycle after the accepted start

        if (jk != 0) begin
            if (job_poke[idx]) begin
                repeat (4) @(posedge clk);
                in_valid <= 1'b1;  // must be ignored
                k        <= 8'd2;
                m        <= 8'd1;
                n        <= 8'd1;
                @(posedge clk);
                in_valid <= 1'b0;
                @(posedge clk);
                check_flag("busy", busy, 1'b1);
            end
            while (busy) begin
                @(posedge clk);
            end
        end

        // nothing more may happen once the job is over
        repeat (8) begin
            @(posedge clk);
            check_flag("busy", busy, 1'b0);
        end

        got = wr_total - job_base;
        assert (got == job_wr[idx]) else begin
            check_errs++;
            show_mismatch("c_wr_en count", c_w'(job_wr[idx]), c_w'(got));
        end
        for (int w = 0; w < got && w < exp_count && w < mem_depth; w++) begin
            assert (c_mem[w] === exp_mem[w]) else begin
                check_errs++;
                show_mismatch($sformatf("c_data_in[%0d]", w), exp_mem[w], c_mem[w]);
            end
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        k        = '0;
        m        = '0;
        n        = '0;
        clear_buffers();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("c_wr_en", c_wr_en, 1'b0);

        for (int j = 0; j < job_count; j++) begin
            run_job(j);
        end

        $display("errors: checks %0d, write path %0d", check_errs, write_errs);
        if (check_errs == 0 && write_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // budget per tile covers read, skew, drain and the C rows
    initial begin : watchdog
        int limit;
        limit = 0;
        for (int j = 0; j < job_count; j++) begin
            limit += tile_count(j) * (job_k[j] + 4*array_dim + 8);
        end
        limit = 2 * limit + 8;
        repeat (limit) @(posedge clk);
        $display("timeout: run still going after %0d cycles", limit);
        $display("errors: checks %0d, write path %0d", check_errs, write_errs);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/tpu_pkg.sv
hw/mac_pe.sv
hw/systolic_array.sv
hw/operand_skewer.sv
hw/tile_controller.sv
hw/tpu_top.sv
verification/tb_tpu.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_tpu
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
FAIL_MSG   := Result: FAILED
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation stopped without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
